// File: m68kAlu.f
rtl/aluPkg.sv
rtl/rowDecoder.sv
rtl/opTable.sv
rtl/aluSequencer.sv
rtl/shiftCounter.sv
rtl/aluDatapath.sv
rtl/ccrUnit.sv
rtl/m68kAlu.sv
tb/aluTb.sv

// File: run.sh
#!/bin/sh
# Builds the m68kAlu testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module aluTb -f m68kAlu.f -o simAlu
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/simAlu 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^Regression passed$"; then
	exit 0
fi
exit 1

// File: tb/aluTb.sv
// Testbench for the 68000-style ALU
// Random and directed register instructions checked against a reference model

`timescale 1ns/10ps

module aluTb;
	import aluPkg::*;

	localparam int numInstr = 200;
	localparam int timeoutCycles = numInstr * 16; // Worst case about 15 cycles each

	logic clk = 1'b0;
	logic rstN;
	logic start;
	word_t ird;
	word_t dataOperand;
	word_t addrOperand;
	logic ccrLoad;
	ccr_t ccrIn;
	logic busy;
	logic done;
	word_t result;
	logic [7:0] ccr;

	logic [31:0] lfsr;
	ccr_t modelCcr;       // CCR as the reference sees it
	int cycleCount = 0;
	int issued = 0;
	int checked = 0;
	word_t expResQ[$];
	ccr_t expCcrQ[$];
	int expCycleQ[$];     // Cycle of the expected done pulse
	word_t heldRes;
	ccr_t heldCcr;
	int expCycle;
	logic holdPending = 1'b0;

	m68kAlu DUT (
		.clk(clk), .rstN(rstN), .start(start), .ird(ird), .dataOperand(dataOperand),
		.addrOperand(addrOperand), .ccrLoad(ccrLoad), .ccrIn(ccrIn), .busy(busy),
		.done(done), .result(result), .ccr(ccr)
	);

	always #2 clk = ~clk; // 4 ns period

	function automatic logic [31:0] galoisStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// One LFSR step per bit
	task automatic takeBits(input int n, output logic [15:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = galoisStep(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s, got %0h expected %0h", $time, what, got, exp);
			$display("Regression failed");
			$fatal(1, "value check failed");
		end
	endtask

	// Register form of a two-operand op, size 00 byte / 01 word
	function automatic word_t regIrd(input logic [3:0] grp, input logic bit8,
		input logic byteSz);
		return {grp, 3'd2, bit8, 1'b0, ~byteSz, 6'b000001};
	endfunction

	// Immediate-count register shift, type 00 AS 01 LS 10 ROX 11 RO
	function automatic word_t shiftIrd(input logic [1:0] kind, input logic left,
		input logic [2:0] count, input logic byteSz);
		return {4'he, count, left, 1'b0, ~byteSz, 1'b0, kind, 3'b011};
	endfunction

	function automatic int stepCount(input word_t irdVal);
		if (irdVal[15:12] != 4'he) begin
			return 1;
		end
		return (irdVal[11:9] == 3'd0) ? 8 : int'(irdVal[11:9]);
	endfunction

	// Expected {XNZVC, result} from the instruction rules
	function automatic logic [20:0] refAlu(input word_t irdVal, input word_t d, input word_t a,
		input ccr_t prev);
		word_t m;
		word_t dv;
		word_t av;
		word_t r;
		logic [16:0] wide;
		int sb;
		int i;
		logic x, c, v, out;
		logic [2:0] kind;
		m = (irdVal[7:6] == 2'b00) ? 16'h00ff : 16'hffff;
		sb = (irdVal[7:6] == 2'b00) ? 7 : 15;
		dv = d & m;
		av = a & m;
		x = prev[4];
		c = 1'b0;
		v = 1'b0;
		r = '0;
		case (irdVal[15:12])
			4'hd: begin
				wide = {1'b0, dv} + {1'b0, av};
				r = wide[15:0] & m;
				c = wide[sb + 1];
				x = c;
				v = (dv[sb] == av[sb]) && (r[sb] != dv[sb]);
			end
			4'h9, 4'hb: begin
				if (irdVal[15:12] == 4'hb && irdVal[8]) begin
					r = dv ^ av; // EOR
				end else begin
					r = (dv - av) & m;
					c = (dv < av); // Borrow
					v = (dv[sb] != av[sb]) && (r[sb] != dv[sb]);
					if (irdVal[15:12] == 4'h9) begin
						x = c; // CMP leaves X
					end
				end
			end
			4'hc: r = dv & av;
			4'h8: r = dv | av;
			default: begin
				kind = {irdVal[4:3], irdVal[8]};
				r = av;
				out = 1'b0;
				for (i = 0; i < stepCount(irdVal); i++) begin
					case (kind)
						3'd1: begin // ASL
							out = r[sb];
							r = (r << 1) & m;
							if (r[sb] != out) begin
								v = 1'b1; // Sign changed at some step
							end
							x = out;
						end
						3'd3: begin
							out = r[sb];
							r = (r << 1) & m;
							x = out;
						end
						3'd0: begin // ASR keeps sign
							out = r[0];
							r = (r >> 1) | ({15'd0, r[sb]} << sb);
							x = out;
						end
						3'd2: begin
							out = r[0];
							r = r >> 1;
							x = out;
						end
						3'd7: begin
							out = r[sb];
							r = ((r << 1) | {15'd0, out}) & m;
						end
						3'd6: begin
							out = r[0];
							r = (r >> 1) | ({15'd0, out} << sb);
						end
						3'd5: begin // ROXL through X
							out = r[sb];
							r = ((r << 1) | {15'd0, x}) & m;
							x = out;
						end
						default: begin
							out = r[0];
							r = (r >> 1) | ({15'd0, x} << sb);
							x = out;
						end
					endcase
				end
				c = out;
			end
		endcase
		return {x, r[sb], (r == 16'h0000), v, c, r};
	endfunction

	task automatic loadCcr(input ccr_t val);
		@(posedge clk);
		#1;
		ccrLoad = 1'b1;
		ccrIn = val;
		@(posedge clk);
		#1;
		ccrLoad = 1'b0;
		modelCcr = val;
	endtask

	// Issues one instruction, optionally with a start and CCR load while busy
	task automatic runInstr(input word_t irdVal, input word_t d, input word_t a,
		input logic spurious);
		logic [20:0] exp;
		logic [15:0] junk;
		exp = refAlu(irdVal, d, a, modelCcr);
		@(posedge clk);
		#1;
		ird = irdVal;
		dataOperand = d;
		addrOperand = a;
		start = 1'b1;
		expResQ.push_back(exp[15:0]);
		expCcrQ.push_back(exp[20:16]);
		expCycleQ.push_back(cycleCount + 4 + stepCount(irdVal)); // Done after edge 3+N
		modelCcr = exp[20:16];
		issued++;
		@(posedge clk);
		#1;
		start = spurious;
		if (spurious) begin
			takeBits(16, junk);
			ird = junk;
			dataOperand = ~junk;
			addrOperand = junk ^ 16'h5a5a;
			ccrLoad = 1'b1; // Must be ignored while busy
			ccrIn = junk[4:0];
			@(posedge clk);
			#1;
			start = 1'b0;
			ccrLoad = 1'b0;
		end
		@(negedge clk);
		while (!done) begin
			checkEq({31'd0, busy}, 32'd1, "busy while running");
			@(negedge clk);
		end
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout: run passed %0d cycles without finishing", timeoutCycles);
			$display("Regression failed");
			$fatal(1, "timeout");
		end
	end

	// Compares results on the done pulse and one cycle later
	always @(negedge clk) begin
		if (holdPending) begin
			checkEq({16'd0, result}, {16'd0, heldRes}, "result holds after done");
			checkEq({24'd0, ccr}, {27'd0, heldCcr}, "ccr holds after done");
			holdPending = 1'b0;
		end
		if (rstN && done) begin
			if (expResQ.size() == 0) begin
				$display("Error: done pulse with no instruction outstanding");
				$display("Regression failed");
				$fatal(1, "unexpected done");
			end else begin
				heldRes = expResQ.pop_front();
				heldCcr = expCcrQ.pop_front();
				expCycle = expCycleQ.pop_front();
				checkEq({16'd0, result}, {16'd0, heldRes}, "result");
				checkEq({24'd0, ccr}, {27'd0, heldCcr}, "ccr XNZVC");
				checkEq(cycleCount, expCycle, "done latency");
				checkEq({31'd0, busy}, 32'd0, "busy low with done");
				checked++;
				holdPending = 1'b1;
			end
		end
	end

	initial begin : stimulus
		logic [15:0] rnd;
		logic [15:0] d;
		logic [15:0] a;
		logic [3:0] grp;
		logic [2:0] kind;
		logic byteSz;
		logic spur;
		int i;
		rstN = 1'b0;
		start = 1'b0;
		ird = '0;
		dataOperand = '0;
		addrOperand = '0;
		ccrLoad = 1'b0;
		ccrIn = '0;
		lfsr = 32'hdbe9;
		modelCcr = '0;
		repeat (2) @(posedge clk);
		#1;
		rstN = 1'b1;
		@(negedge clk);
		checkEq({31'd0, busy}, 32'd0, "busy after reset");
		checkEq({31'd0, done}, 32'd0, "done after reset");
		checkEq({24'd0, ccr}, 32'd0, "ccr after reset");
		checkEq({16'd0, result}, 32'd0, "result after reset");

		// ADD, SUB, CMP
		for (i = 0; i < 60; i++) begin
			takeBits(4, rnd);
			grp = (rnd[1:0] == 2'd0) ? 4'hd : (rnd[1:0] == 2'd1) ? 4'h9 : 4'hb;
			byteSz = rnd[2];
			spur = rnd[3];
			takeBits(16, d);
			takeBits(16, a);
			runInstr(regIrd(grp, 1'b0, byteSz), d, a, spur);
		end

		// AND, OR, EOR with V and C preset
		for (i = 0; i < 48; i++) begin
			takeBits(9, rnd);
			grp = (rnd[1:0] == 2'd0) ? 4'hc : (rnd[1:0] == 2'd1) ? 4'h8 : 4'hb;
			byteSz = rnd[2];
			spur = rnd[3];
			loadCcr(rnd[8:4]);
			takeBits(16, d);
			takeBits(16, a);
			runInstr(regIrd(grp, 1'b1, byteSz), d, a, spur);
		end

		// All eight shifts, random count and preloaded X
		kind = 3'd0;
		for (i = 0; i < 80; i++) begin
			takeBits(10, rnd);
			byteSz = rnd[3];
			spur = rnd[4];
			loadCcr(rnd[9:5]);
			takeBits(16, a);
			runInstr(shiftIrd(kind[2:1], kind[0], rnd[2:0], byteSz), 16'h0000, a, spur);
			kind = kind + 3'd1;
		end

		// Corner cases
		loadCcr(5'b00000);
		runInstr(shiftIrd(2'b00, 1'b1, 3'd3, 1'b1), 16'h0000, 16'h0040, 1'b0); // V sticks
		runInstr(shiftIrd(2'b00, 1'b1, 3'd2, 1'b0), 16'h0000, 16'h4000, 1'b0);
		runInstr(shiftIrd(2'b00, 1'b1, 3'd1, 1'b0), 16'h0000, 16'h3fff, 1'b0); // No V
		loadCcr(5'b10000);
		runInstr(shiftIrd(2'b10, 1'b1, 3'd1, 1'b1), 16'h0000, 16'h0080, 1'b0); // X in, MSB out
		loadCcr(5'b10000);
		runInstr(shiftIrd(2'b10, 1'b0, 3'd0, 1'b0), 16'h0000, 16'h1234, 1'b0);
		loadCcr(5'b00000);
		runInstr(shiftIrd(2'b10, 1'b1, 3'd0, 1'b0), 16'h0000, 16'h8001, 1'b1);
		runInstr(regIrd(4'hd, 1'b0, 1'b1), 16'h007f, 16'h0001, 1'b0);  // Byte overflow
		runInstr(regIrd(4'h9, 1'b0, 1'b0), 16'h0000, 16'h0001, 1'b0);  // Borrow
		loadCcr(5'b11111);
		runInstr(regIrd(4'hb, 1'b0, 1'b0), 16'h1234, 16'h1234, 1'b0);  // CMP equal
		runInstr(regIrd(4'hc, 1'b0, 1'b0), 16'hf0f0, 16'h0f0f, 1'b0);  // Zero result
		runInstr(shiftIrd(2'b01, 1'b0, 3'd0, 1'b1), 16'h0000, 16'h00ff, 1'b0);
		runInstr(shiftIrd(2'b00, 1'b0, 3'd0, 1'b1), 16'h0000, 16'h0080, 1'b0); // Sign fill

		repeat (3) @(posedge clk);
		if (checked == issued && expResQ.size() == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("Error: %0d instructions issued but %0d checked", issued, checked);
			$display("Regression failed");
			$fatal(1, "missing checks");
		end
	end

endmodule

// File: rtl/m68kAlu.sv
// 68000-style ALU top level
// Sequencer, step counter, decode, op table, datapath and CCR

`timescale 1ns/10ps

module m68kAlu (
	input  logic          clk,
	input  logic          rstN,
	input  logic          start,
	input  aluPkg::word_t ird,
	input  aluPkg::word_t dataOperand,
	input  aluPkg::word_t addrOperand,
	input  logic          ccrLoad,
	input  aluPkg::ccr_t  ccrIn,
	output logic          busy,
	output logic          done,
	output aluPkg::word_t result,
	output logic [7:0]    ccr
);
	import aluPkg::*;

	logic capture, decodeEn, opSelEn, execEn, firstStep, ccrWrite;
	logic lastStep;
	row_t row;
	logic isByte, isShift;
	logic [2:0] shiftCount;
	col_t col;
	aluOp_e aluOp;
	ccr_t ccrMask, flagsRaw, ccrFlags;

	assign col = isShift ? colShift : colArith; // Shift rows live in column 4
	assign ccr = {3'b000, ccrFlags};

	aluSequencer uSeq (
		.clk(clk), .rstN(rstN), .start(start), .lastStep(lastStep), .ccrLoad(ccrLoad),
		.capture(capture), .decodeEn(decodeEn), .opSelEn(opSelEn), .execEn(execEn),
		.firstStep(firstStep), .ccrWrite(ccrWrite), .busy(busy), .done(done)
	);

	shiftCounter uCnt (
		.clk(clk), .rstN(rstN), .load(opSelEn), .step(execEn),
		.isShift(isShift), .shiftCount(shiftCount), .lastStep(lastStep)
	);

	rowDecoder uDec (
		.clk(clk), .rstN(rstN), .ird(ird), .decodeEn(decodeEn), .row(row),
		.isByte(isByte), .isShift(isShift), .shiftCount(shiftCount)
	);

	opTable uOps (
		.clk(clk), .rstN(rstN), .opSelEn(opSelEn), .row(row), .col(col),
		.aluOp(aluOp), .ccrMask(ccrMask)
	);

	aluDatapath uDp (
		.clk(clk), .rstN(rstN), .capture(capture), .execEn(execEn), .firstStep(firstStep),
		.dataOperand(dataOperand), .addrOperand(addrOperand), .aluOp(aluOp),
		.isByte(isByte), .ccrFlags(ccrFlags), .result(result), .flagsRaw(flagsRaw)
	);

	ccrUnit uCcr (
		.clk(clk), .rstN(rstN), .execEn(execEn), .ccrWrite(ccrWrite), .ccrIn(ccrIn),
		.flagsRaw(flagsRaw), .ccrMask(ccrMask), .ccrFlags(ccrFlags)
	);

endmodule

// File: rtl/ccrUnit.sv
// Condition code register
// Masked merge of the ALU flags, plus a direct load path

`timescale 1ns/10ps

module ccrUnit (
	input  logic         clk,
	input  logic         rstN,
	input  logic         execEn,
	input  logic         ccrWrite,
	input  aluPkg::ccr_t ccrIn,
	input  aluPkg::ccr_t flagsRaw,
	input  aluPkg::ccr_t ccrMask,
	output aluPkg::ccr_t ccrFlags
);
	import aluPkg::*;

	ccr_t merged;

	// Masked bits take the new flag, the rest keep their value
	assign merged = (flagsRaw & ccrMask) | (ccrFlags & ~ccrMask);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ccrFlags <= '0;
		end else if (ccrWrite) begin
			ccrFlags <= ccrIn; // External load, all five flags
		end else if (execEn) begin
			ccrFlags <= merged; // Every execute step
		end
	end

endmodule

// File: rtl/aluDatapath.sv
// ALU datapath
// Operand latches, adder/subtractor, logic ops, one-bit shifter and raw flags

`timescale 1ns/10ps

module aluDatapath (
	input  logic           clk,
	input  logic           rstN,
	input  logic           capture,
	input  logic           execEn,
	input  logic           firstStep,
	input  aluPkg::word_t  dataOperand,
	input  aluPkg::word_t  addrOperand,
	input  aluPkg::aluOp_e aluOp,
	input  logic           isByte,
	input  aluPkg::ccr_t   ccrFlags,
	output aluPkg::word_t  result,
	output aluPkg::ccr_t   flagsRaw
);
	import aluPkg::*;

	word_t dLatch;   // Destination, minuend
	word_t aLatch;   // Source, subtrahend, shifted value
	word_t resLatch;
	word_t shiftSrc;
	word_t rawRes;
	word_t nextRes;
	logic [16:0] sum;
	logic isSub, carry, ovf;
	logic dMsb, aMsb, sMsb;
	logic msb, nextMsb, lsb;

	// One bit shift at the operand size, bitIn enters at the vacated end
	function automatic word_t shiftOne(input word_t v, input logic right,
		input logic bitIn, input logic byteSz);
		word_t r;
		if (!right) begin
			r = {v[14:0], bitIn};
		end else if (byteSz) begin
			r = {8'h00, bitIn, v[7:1]};
		end else begin
			r = {bitIn, v[15:1]};
		end
		return r;
	endfunction

	always_ff @(posedge clk) begin
		if (capture) begin
			dLatch <= dataOperand;
			aLatch <= addrOperand;
		end
	end

	always_comb begin
		// Adder, sub is data minus addr
		isSub = (aluOp == opSub);
		if (isByte) begin
			sum = isSub ? {9'd0, dLatch[7:0]} - {9'd0, aLatch[7:0]}
				: {9'd0, dLatch[7:0]} + {9'd0, aLatch[7:0]};
		end else begin
			sum = isSub ? {1'b0, dLatch} - {1'b0, aLatch} : {1'b0, dLatch} + {1'b0, aLatch};
		end
		carry = isByte ? sum[8] : sum[16]; // Carry or borrow
		dMsb = isByte ? dLatch[7] : dLatch[15];
		aMsb = isByte ? aLatch[7] : aLatch[15];
		sMsb = isByte ? sum[7] : sum[15];
		ovf = (isSub ? (dMsb ^ aMsb) : ~(dMsb ^ aMsb)) & (sMsb ^ dMsb);

		// Shifter works on the operand first, then on its own result
		shiftSrc = firstStep ? aLatch : resLatch;
		msb = isByte ? shiftSrc[7] : shiftSrc[15];
		nextMsb = isByte ? shiftSrc[6] : shiftSrc[14];
		lsb = shiftSrc[0];

		rawRes = sum[15:0];
		flagsRaw = '0;
		flagsRaw[flagX] = ccrFlags[flagX]; // Kept unless the op sets it
		case (aluOp)
			opAdd, opSub: begin
				flagsRaw[flagC] = carry;
				flagsRaw[flagX] = carry;
				flagsRaw[flagV] = ovf;
			end
			opAnd: rawRes = dLatch & aLatch;
			opOr: rawRes = dLatch | aLatch;
			opEor: rawRes = dLatch ^ aLatch;
			opAsl: begin
				rawRes = shiftOne(shiftSrc, 1'b0, 1'b0, isByte);
				flagsRaw[flagC] = msb;
				flagsRaw[flagX] = msb;
				// Sticky over the loop, fresh on the first step
				flagsRaw[flagV] = (~firstStep & ccrFlags[flagV]) | (msb ^ nextMsb);
			end
			opLsl: begin
				rawRes = shiftOne(shiftSrc, 1'b0, 1'b0, isByte);
				flagsRaw[flagC] = msb;
				flagsRaw[flagX] = msb;
			end
			opAsr: begin
				rawRes = shiftOne(shiftSrc, 1'b1, msb, isByte); // Sign fill
				flagsRaw[flagC] = lsb;
				flagsRaw[flagX] = lsb;
			end
			opLsr: begin
				rawRes = shiftOne(shiftSrc, 1'b1, 1'b0, isByte);
				flagsRaw[flagC] = lsb;
				flagsRaw[flagX] = lsb;
			end
			opRol: begin
				rawRes = shiftOne(shiftSrc, 1'b0, msb, isByte);
				flagsRaw[flagC] = msb;
			end
			opRor: begin
				rawRes = shiftOne(shiftSrc, 1'b1, lsb, isByte);
				flagsRaw[flagC] = lsb;
			end
			opRoxl: begin
				rawRes = shiftOne(shiftSrc, 1'b0, ccrFlags[flagX], isByte); // X rotates in
				flagsRaw[flagC] = msb;
				flagsRaw[flagX] = msb;
			end
			default: begin
				// ROXR
				rawRes = shiftOne(shiftSrc, 1'b1, ccrFlags[flagX], isByte);
				flagsRaw[flagC] = lsb;
				flagsRaw[flagX] = lsb;
			end
		endcase

		nextRes = isByte ? {8'h00, rawRes[7:0]} : rawRes; // Byte clears upper half
		flagsRaw[flagN] = isByte ? nextRes[7] : nextRes[15];
		flagsRaw[flagZ] = ~|nextRes; // Upper half already clear for bytes
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			resLatch <= '0;
		end else if (execEn) begin
			resLatch <= nextRes;
		end
	end

	assign result = resLatch;

endmodule

// File: rtl/shiftCounter.sv
// Shift step counter
// Counts execute steps down and marks the last one

`timescale 1ns/10ps

module shiftCounter (
	input  logic       clk,
	input  logic       rstN,
	input  logic       load,
	input  logic       step,
	input  logic       isShift,
	input  logic [2:0] shiftCount,
	output logic       lastStep
);
	logic [3:0] count; // Steps left, 1 to 8

	always_ff @(posedge clk) begin
		if (!rstN) begin
			count <= '0;
		end else if (load) begin
			if (!isShift) begin
				count <= 4'd1; // Single pass for arith / logic
			end else begin
				count <= (shiftCount == 3'd0) ? 4'd8 : {1'b0, shiftCount};
			end
		end else if (step) begin
			count <= count - 4'd1;
		end
	end

	assign lastStep = (count == 4'd1);

endmodule

// File: rtl/aluSequencer.sv
// ALU sequencer
// Steps decode, op select and the execute loop; flags busy and done

`timescale 1ns/10ps

module aluSequencer (
	input  logic clk,
	input  logic rstN,
	input  logic start,
	input  logic lastStep,
	input  logic ccrLoad,
	output logic capture,
	output logic decodeEn,
	output logic opSelEn,
	output logic execEn,
	output logic firstStep,
	output logic ccrWrite,
	output logic busy,
	output logic done
);
	typedef enum logic [2:0] {stIdle, stDecode, stOpSel, stExec, stDone} seqState_e;

	seqState_e state;
	seqState_e nextState;
	logic firstPending; // Next exec step is the first one

	always_comb begin
		nextState = state;
		case (state)
			stIdle: begin
				if (start) begin
					nextState = stDecode;
				end
			end
			stDecode: nextState = stOpSel;
			stOpSel: nextState = stExec;
			stExec: begin
				if (lastStep) begin
					nextState = stDone;
				end
			end
			default: nextState = stIdle;
		endcase
	end

	assign capture = (state == stIdle) & start; // Operands sampled with start
	assign decodeEn = (state == stDecode);
	assign opSelEn = (state == stOpSel);
	assign execEn = (state == stExec);
	assign firstStep = execEn & firstPending;
	assign ccrWrite = ccrLoad & (state == stIdle); // External load only when idle

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= stIdle;
			firstPending <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			state <= nextState;
			if (opSelEn) begin
				firstPending <= 1'b1;
			end else if (execEn) begin
				firstPending <= 1'b0;
			end
			if (capture) begin
				busy <= 1'b1;
			end else if (state == stDone) begin
				busy <= 1'b0; // Drops with the done pulse
			end
			done <= (state == stDone); // One cycle pulse
		end
	end

endmodule

// File: rtl/opTable.sv
// Operation and CCR mask table
// Looks up the ALU operation and the flag update mask from row and column

`timescale 1ns/10ps

module opTable (
	input  logic           clk,
	input  logic           rstN,
	input  logic           opSelEn,
	input  aluPkg::row_t   row,
	input  aluPkg::col_t   col,
	output aluPkg::aluOp_e aluOp,
	output aluPkg::ccr_t   ccrMask
);
	import aluPkg::*;

	aluOp_e nextOp;
	ccr_t nextMask;

	always_comb begin
		nextOp = opAnd;
		nextMask = '0; // Unknown rows leave the CCR alone
		if (col == colShift) begin
			nextMask = maskAll;
			case (row)
				row02: nextOp = opAsr;
				row03: nextOp = opAsl; // V accumulates over the loop
				row04: nextOp = opLsl;
				row05: nextOp = opLsr;
				row08: nextOp = opRoxr;
				row11: nextOp = opRoxl;
				row09: begin
					nextOp = opRol;
					nextMask = maskRot;
				end
				row10: begin
					nextOp = opRor;
					nextMask = maskRot;
				end
				default: nextMask = '0;
			endcase
		end else if (col == colArith) begin
			case (row)
				row02: begin
					nextOp = opAdd;
					nextMask = maskAll;
				end
				row05: begin
					nextOp = opSub;
					nextMask = maskAll;
				end
				row06: begin
					// CMP, X untouched
					nextOp = opSub;
					nextMask = maskNzvc;
				end
				row04: begin
					nextOp = opAnd;
					nextMask = maskNzvc;
				end
				row13: begin
					nextOp = opEor;
					nextMask = maskNzvc;
				end
				row14: begin
					nextOp = opOr;
					nextMask = maskNzvc;
				end
				default: nextMask = '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			aluOp <= opAnd;
			ccrMask <= '0;
		end else if (opSelEn) begin
			aluOp <= nextOp;
			ccrMask <= nextMask;
		end
	end

endmodule

// File: rtl/rowDecoder.sv
// Instruction row decoder
// Maps the instruction word to a one-hot ALU row, size and shift count

`timescale 1ns/10ps

module rowDecoder (
	input  logic          clk,
	input  logic          rstN,
	input  aluPkg::word_t ird,
	input  logic          decodeEn,
	output aluPkg::row_t  row,
	output logic          isByte,
	output logic          isShift,
	output logic [2:0]    shiftCount
);
	import aluPkg::*;

	word_t irdReg;
	row_t nextRow;
	logic nextShift;
	logic [1:0] shiftType;

	// Follows ird until the decode cycle, so it holds the word sampled with start
	always_ff @(posedge clk) begin
		if (!decodeEn) begin
			irdReg <= ird;
		end
	end

	assign shiftType = irdReg[4:3]; // Register shift type field

	always_comb begin
		nextRow = '0;
		nextShift = 1'b0;
		case (irdReg[15:12])
			4'h8: nextRow = row14; // OR
			4'h9: nextRow = row05; // SUB
			4'hb: nextRow = irdReg[8] ? row13 : row06; // EOR / CMP
			4'hc: nextRow = row04; // AND
			4'hd: nextRow = row02; // ADD
			4'he: begin
				nextShift = 1'b1;
				// Type bits then direction, bit 8 set means left
				case ({shiftType, irdReg[8]})
					3'd0: nextRow = row02; // ASR
					3'd1: nextRow = row03; // ASL
					3'd2: nextRow = row05; // LSR
					3'd3: nextRow = row04; // LSL
					3'd4: nextRow = row08; // ROXR
					3'd5: nextRow = row11; // ROXL
					3'd6: nextRow = row10; // ROR
					default: nextRow = row09; // ROL
				endcase
			end
			default: nextRow = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			row <= '0;
			isByte <= 1'b0;
			isShift <= 1'b0;
			shiftCount <= '0;
		end else if (decodeEn) begin
			row <= nextRow;
			isByte <= (irdReg[7:6] == 2'b00); // Size field 00 is byte
			isShift <= nextShift;
			shiftCount <= irdReg[11:9]; // Immediate count, 0 means 8
		end
	end

endmodule

// File: rtl/aluPkg.sv
// ALU shared package
// Word, row and flag types, operation codes, decode rows and CCR masks

package aluPkg;

	typedef logic [15:0] word_t; // Operand / result word
	typedef logic [15:0] row_t;  // One-hot ALU row
	typedef logic [4:0]  ccr_t;  // X N Z V C
	typedef logic [2:0]  col_t;  // Microcode column

	typedef enum logic [4:0] {
		opAnd,
		opOr,
		opEor,
		opAdd,
		opSub,
		opAsl,
		opAsr,
		opLsl,
		opLsr,
		opRol,
		opRor,
		opRoxl,
		opRoxr
	} aluOp_e;

	// Bit positions inside the CCR
	localparam int flagC = 0;
	localparam int flagV = 1;
	localparam int flagZ = 2;
	localparam int flagN = 3;
	localparam int flagX = 4;

	localparam col_t colArith = 3'd2; // Plain arithmetic / logic
	localparam col_t colShift = 3'd4; // Shift and rotate loop

	// Rows used by the register-to-register subset
	localparam row_t row02 = 16'h0004;
	localparam row_t row03 = 16'h0008;
	localparam row_t row04 = 16'h0010;
	localparam row_t row05 = 16'h0020;
	localparam row_t row06 = 16'h0040;
	localparam row_t row08 = 16'h0100;
	localparam row_t row09 = 16'h0200;
	localparam row_t row10 = 16'h0400;
	localparam row_t row11 = 16'h0800;
	localparam row_t row13 = 16'h2000;
	localparam row_t row14 = 16'h4000;

	localparam ccr_t maskAll  = 5'b11111; // Update XNZVC
	localparam ccr_t maskNzvc = 5'b01111; // X kept
	localparam ccr_t maskRot  = 5'b01111; // ROL/ROR, X kept

endpackage
